//--- hdl/gemm_cfg_pkg.sv
`default_nettype none

package gemm_cfg_pkg;

    // Array geometry.
    localparam int DIM = 4;

    // Operand and accumulator widths.
    localparam int A_W   = 16;
    localparam int B_W   = 8;
    localparam int ACC_W = 40;

    // Beat counter, wide enough for 65536 beats.
    localparam int DEPTH_W = 17;

    typedef logic signed [A_W-1:0]   a_elem_t;
    typedef logic signed [B_W-1:0]   b_elem_t;
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

//--- hdl/gemm_types_pkg.sv
`default_nettype none

package gemm_types_pkg;

    // One A column per beat, lane 0 is array row 0.
    typedef struct packed {
        gemm_cfg_pkg::a_elem_t [gemm_cfg_pkg::DIM-1:0] lane;
    } a_vec_t;

    // One B row per beat, lane 0 is array column 0.
    typedef struct packed {
        gemm_cfg_pkg::b_elem_t [gemm_cfg_pkg::DIM-1:0] lane;
    } b_vec_t;

    // Input payload of the top level.
    typedef struct packed {
        a_vec_t a;
        b_vec_t b;
        logic   last;  // Final beat of the job.
    } beat_t;

    typedef struct packed {
        logic busy;    // Job in progress, through the done cycle.
        logic done;    // One cycle pulse, result is final.
        logic error;   // Sticky until the next job starts.
    } gemm_status_t;

endpackage

`default_nettype wire

//--- hdl/beat_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module beat_sequencer #(
    parameter int MAX_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  gemm_types_pkg::beat_t        beat,
    output gemm_types_pkg::a_vec_t       a_feed,
    output gemm_types_pkg::b_vec_t       b_feed,
    output logic                         clear,
    output gemm_types_pkg::gemm_status_t status
);

    localparam int DRAIN_CYCLES = 2 * gemm_cfg_pkg::DIM + 1;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FEED,
        S_DRAIN
    } state_t;

    state_t                           state;
    logic [gemm_cfg_pkg::DEPTH_W-1:0] beat_cnt;
    logic [gemm_cfg_pkg::DEPTH_W-1:0] beat_cnt_next;
    logic [DRAIN_W-1:0]               drain_cnt;
    logic                             error_q;
    logic                             accept;
    logic                             start;
    logic                             at_depth;
    logic                             overflow;
    logic                             feed_end;
    logic                             dropped;

    assign accept        = in_valid && (state != S_DRAIN);
    assign start         = accept && (state == S_IDLE);
    assign dropped       = in_valid && (state == S_DRAIN);
    assign beat_cnt_next = start ? gemm_cfg_pkg::DEPTH_W'(1) : beat_cnt + 1'b1;
    assign at_depth      = (beat_cnt_next == gemm_cfg_pkg::DEPTH_W'(MAX_DEPTH));
    assign overflow      = accept && !beat.last && at_depth;
    assign feed_end      = accept && (beat.last || at_depth);  // Depth limit forces the end.

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            beat_cnt  <= '0;
            drain_cnt <= '0;
            error_q   <= 1'b0;
            clear     <= 1'b0;
            a_feed    <= '0;
            b_feed    <= '0;
        end else begin
            clear  <= start;
            a_feed <= accept ? beat.a : '0;  // Idle cycles feed zeros.
            b_feed <= accept ? beat.b : '0;

            if (accept) begin
                beat_cnt <= beat_cnt_next;
            end

            if (start) begin
                error_q <= overflow;
            end else if (overflow || dropped) begin
                error_q <= 1'b1;
            end

            case (state)
                S_IDLE, S_FEED: begin
                    if (feed_end) begin
                        state     <= S_DRAIN;
                        drain_cnt <= DRAIN_W'(DRAIN_CYCLES);
                    end else if (start) begin
                        state <= S_FEED;
                    end
                end
                S_DRAIN: begin
                    drain_cnt <= drain_cnt - 1'b1;
                    if (drain_cnt == DRAIN_W'(1)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Done sits in the last drain cycle, when cell (DIM-1,DIM-1) is final.
    assign status = '{
        busy:  (state != S_IDLE),
        done:  (state == S_DRAIN) && (drain_cnt == DRAIN_W'(1)),
        error: error_q
    };

endmodule

`default_nettype wire

//--- hdl/operand_skew.sv
`timescale 1ns/1ps
`default_nettype none

module operand_skew #(
    parameter type elem_t = gemm_cfg_pkg::a_elem_t
) (
    input  logic  clk,
    input  logic  rst,
    input  elem_t lanes_in  [gemm_cfg_pkg::DIM],
    output elem_t lanes_out [gemm_cfg_pkg::DIM]
);

    // Lane i is a shift line of i+1 registers.
    for (genvar i = 0; i < gemm_cfg_pkg::DIM; i++) begin : g_lane
        elem_t stage [0:i];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int s = 0; s <= i; s++) begin
                    stage[s] <= '0;
                end
            end else begin
                stage[0] <= lanes_in[i];
                for (int s = 1; s <= i; s++) begin
                    stage[s] <= stage[s-1];
                end
            end
        end

        assign lanes_out[i] = stage[i];  // Oldest sample of the lane.
    end

endmodule

`default_nettype wire

//--- hdl/mac_pe_grid.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pe_grid (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  gemm_cfg_pkg::a_elem_t a_west  [gemm_cfg_pkg::DIM],
    input  gemm_cfg_pkg::b_elem_t b_north [gemm_cfg_pkg::DIM],
    output gemm_cfg_pkg::acc_t    result  [gemm_cfg_pkg::DIM][gemm_cfg_pkg::DIM]
);

    localparam int DIM    = gemm_cfg_pkg::DIM;
    localparam int PROD_W = gemm_cfg_pkg::A_W + gemm_cfg_pkg::B_W;

    // Operand links between neighbouring cells.
    gemm_cfg_pkg::a_elem_t a_pass [DIM][DIM-1];
    gemm_cfg_pkg::b_elem_t b_pass [DIM-1][DIM];
    gemm_cfg_pkg::acc_t    acc    [DIM][DIM];

    for (genvar i = 0; i < DIM; i++) begin : g_row
        for (genvar j = 0; j < DIM; j++) begin : g_col
            gemm_cfg_pkg::a_elem_t     a_in;
            gemm_cfg_pkg::b_elem_t     b_in;
            logic signed [PROD_W-1:0] prod;

            if (j == 0) begin : g_a_edge
                assign a_in = a_west[i];
            end else begin : g_a_link
                assign a_in = a_pass[i][j-1];
            end

            if (i == 0) begin : g_b_edge
                assign b_in = b_north[j];
            end else begin : g_b_link
                assign b_in = b_pass[i-1][j];
            end

            assign prod = a_in * b_in;

            always_ff @(posedge clk) begin
                if (rst || clear) begin
                    acc[i][j] <= '0;
                end else begin
                    acc[i][j] <= acc[i][j] + gemm_cfg_pkg::acc_t'(prod);  // Sign extends.
                end
            end

            // East register, absent in the last column.
            if (j < DIM - 1) begin : g_east
                always_ff @(posedge clk) begin
                    if (rst) begin
                        a_pass[i][j] <= '0;
                    end else begin
                        a_pass[i][j] <= a_in;
                    end
                end
            end

            // South register, absent in the last row.
            if (i < DIM - 1) begin : g_south
                always_ff @(posedge clk) begin
                    if (rst) begin
                        b_pass[i][j] <= '0;
                    end else begin
                        b_pass[i][j] <= b_in;
                    end
                end
            end
        end
    end

    assign result = acc;

endmodule

`default_nettype wire

//--- hdl/systolic_gemm_top.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_gemm_top #(
    parameter int MAX_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  gemm_types_pkg::beat_t        beat,
    output gemm_cfg_pkg::acc_t           result [gemm_cfg_pkg::DIM][gemm_cfg_pkg::DIM],
    output gemm_types_pkg::gemm_status_t status
);

    gemm_types_pkg::a_vec_t a_feed;
    gemm_types_pkg::b_vec_t b_feed;
    logic                   clear;

    gemm_cfg_pkg::a_elem_t a_lanes  [gemm_cfg_pkg::DIM];
    gemm_cfg_pkg::a_elem_t a_skewed [gemm_cfg_pkg::DIM];
    gemm_cfg_pkg::b_elem_t b_lanes  [gemm_cfg_pkg::DIM];
    gemm_cfg_pkg::b_elem_t b_skewed [gemm_cfg_pkg::DIM];

    beat_sequencer #(
        .MAX_DEPTH (MAX_DEPTH)
    ) u_seq (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .beat     (beat),
        .a_feed   (a_feed),
        .b_feed   (b_feed),
        .clear    (clear),
        .status   (status)
    );

    // Packed feed vectors to per-lane arrays.
    for (genvar i = 0; i < gemm_cfg_pkg::DIM; i++) begin : g_unpack
        assign a_lanes[i] = a_feed.lane[i];
        assign b_lanes[i] = b_feed.lane[i];
    end

    operand_skew #(
        .elem_t (gemm_cfg_pkg::a_elem_t)
    ) u_skew_a (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (a_lanes),
        .lanes_out (a_skewed)
    );

    operand_skew #(
        .elem_t (gemm_cfg_pkg::b_elem_t)
    ) u_skew_b (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (b_lanes),
        .lanes_out (b_skewed)
    );

    mac_pe_grid u_grid (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .a_west  (a_skewed),  // Rows enter from the west.
        .b_north (b_skewed),  // Columns enter from the north.
        .result  (result)
    );

endmodule

`default_nettype wire

//--- test/systolic_gemm_properties.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_gemm_properties (
    input logic                         clk,
    input logic                         rst,
    input logic                         accept,
    input logic                         last,
    input gemm_types_pkg::gemm_status_t status
);

    localparam int DRAIN_CYCLES = 2 * gemm_cfg_pkg::DIM + 1;

    // Done only inside a job, and the job ends with it.
    a_done_in_job: assert property (@(posedge clk) disable iff (rst)
        status.done |-> status.busy ##1 !status.busy)
        else $error("done is high while busy is low, or busy outlives done");

    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        (accept && last) |=> !status.done [*(DRAIN_CYCLES-1)] ##1 status.done)
        else $error("done did not follow the last beat by the drain latency");

    a_reset_status: assert property (@(posedge clk)
        rst |=> (status == '0))
        else $error("status is not clear after reset");

endmodule

bind systolic_gemm_top systolic_gemm_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .accept (u_seq.accept),
    .last   (beat.last),
    .status (status)
);

`default_nettype wire

//--- test/tb_systolic_gemm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_systolic_gemm;

    localparam int DIM          = gemm_cfg_pkg::DIM;
    localparam int MAX_K        = 8;
    localparam int DRAIN_CYCLES = 2 * DIM + 1;
    localparam int DONE_LIMIT   = 4 * DRAIN_CYCLES;
    localparam int TOTAL_BEATS  = 51;  // Beat, gap and dropped slots over all jobs.
    localparam int NUM_TESTS    = 8;
    localparam int WATCHDOG_NS  = (TOTAL_BEATS + 2 * DIM + 10) * 20 * NUM_TESTS;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         in_valid;
    gemm_types_pkg::beat_t        beat;
    gemm_cfg_pkg::acc_t           result [DIM][DIM];
    gemm_types_pkg::gemm_status_t status;

    gemm_cfg_pkg::a_elem_t a_mat   [DIM][MAX_K];
    gemm_cfg_pkg::b_elem_t b_mat   [MAX_K][DIM];
    gemm_cfg_pkg::acc_t    exp_mat [DIM][DIM];
    int                    errors       = 0;
    int                    tests_run    = 0;
    int                    tests_failed = 0;

    systolic_gemm_top #(
        .MAX_DEPTH (8)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .beat     (beat),
        .result   (result),
        .status   (status)
    );

    always #10 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic fill_random(input int k);
        for (int kk = 0; kk < k; kk++) begin
            for (int i = 0; i < DIM; i++) begin
                a_mat[i][kk] = gemm_cfg_pkg::a_elem_t'($urandom);
                b_mat[kk][i] = gemm_cfg_pkg::b_elem_t'($urandom);
            end
        end
    endtask

    // Plain dot products in 40-bit signed arithmetic.
    task automatic reference_product(input int k);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                exp_mat[i][j] = '0;
                for (int kk = 0; kk < k; kk++) begin
                    exp_mat[i][j] += gemm_cfg_pkg::acc_t'(a_mat[i][kk])
                                   * gemm_cfg_pkg::acc_t'(b_mat[kk][j]);
                end
            end
        end
    endtask

    function automatic gemm_types_pkg::beat_t random_beat(input logic last);
        gemm_types_pkg::beat_t b;
        b.last = last;
        for (int i = 0; i < DIM; i++) begin
            b.a.lane[i] = gemm_cfg_pkg::a_elem_t'($urandom);
            b.b.lane[i] = gemm_cfg_pkg::b_elem_t'($urandom);
        end
        return b;
    endfunction

    function automatic string status_text(input gemm_types_pkg::gemm_status_t s);
        return $sformatf("busy=%b done=%b error=%b", s.busy, s.done, s.error);
    endfunction

    task automatic drive_beat(input int kk, input logic last);
        gemm_types_pkg::beat_t b;
        b.last = last;
        for (int i = 0; i < DIM; i++) begin
            b.a.lane[i] = a_mat[i][kk];
            b.b.lane[i] = b_mat[kk][i];
        end
        @(posedge clk);
        in_valid <= 1'b1;
        beat     <= b;
    endtask

    task automatic drive_noise();
        gemm_types_pkg::beat_t b;
        b = random_beat(1'b1);
        @(posedge clk);
        in_valid <= 1'b1;
        beat     <= b;
    endtask

    // Garbage payload with valid low, the sequencer has to mask it.
    task automatic drive_idle();
        gemm_types_pkg::beat_t b;
        b = random_beat(1'b1);
        @(posedge clk);
        in_valid <= 1'b0;
        beat     <= b;
    endtask

    // Edges_after counts the posedges already spent since the last beat was driven.
    task automatic wait_done(input string name, input int edges_after);
        int cycles;
        cycles = edges_after - 1;
        @(negedge clk);
        cycles++;
        while (!status.done && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!status.done) begin
            $display("Error: %s: done never arrived after the last beat", name);
            errors++;
        end else if (cycles != DRAIN_CYCLES) begin
            $display("Mismatch %s done latency expected %0d actual %0d",
                     name, DRAIN_CYCLES, cycles);
            errors++;
        end
    endtask

    task automatic check_result(input string name,
                                input gemm_cfg_pkg::acc_t exp_val [DIM][DIM],
                                input gemm_cfg_pkg::acc_t act_val [DIM][DIM]);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                if (act_val[i][j] !== exp_val[i][j]) begin
                    $display("Mismatch %s result[%0d][%0d] expected %0d actual %0d",
                             name, i, j, exp_val[i][j], act_val[i][j]);
                    errors++;
                end
            end
        end
    endtask

    task automatic check_status(input string name,
                                input gemm_types_pkg::gemm_status_t exp_val,
                                input gemm_types_pkg::gemm_status_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s status expected %s actual %s",
                     name, status_text(exp_val), status_text(act_val));
            errors++;
        end
    endtask

    task automatic run_job(input string name, input int k, input bit gaps,
                           input int extras, input bit use_last, input logic exp_error);
        int errors_before;
        errors_before = errors;
        reference_product(k);
        for (int kk = 0; kk < k; kk++) begin
            if (gaps && kk > 0) begin
                drive_idle();  // Idle slot inside the job.
            end
            drive_beat(kk, use_last && (kk == k - 1));
        end
        for (int n = 0; n < extras; n++) begin
            drive_noise();  // Lands in the drain, must be dropped.
        end
        drive_idle();
        wait_done(name, extras + 1);
        check_result(name, exp_mat, result);
        check_status(name, '{busy: 1'b1, done: 1'b1, error: exp_error}, status);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("Test %-16s fail", name);
        end
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        beat     = '0;
        void'($urandom(33295));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_status("reset", '0, status);

        fill_random(4);
        for (int i = 0; i < DIM; i++) begin
            for (int kk = 0; kk < 4; kk++) begin
                a_mat[i][kk] = (i == kk) ? 16'sd1 : 16'sd0;
            end
        end
        run_job("identity", 4, 0, 0, 1, 1'b0);

        fill_random(7);
        a_mat[0][0] = -16'sd32768;
        a_mat[1][6] = -16'sd32768;
        a_mat[2][3] = 16'sd32767;
        b_mat[0][0] = -8'sd128;
        b_mat[6][1] = -8'sd128;
        b_mat[3][2] = 8'sd127;
        run_job("signed_extremes", 7, 0, 0, 1, 1'b0);

        fill_random(6);
        run_job("back_to_back_1", 6, 0, 0, 1, 1'b0);
        fill_random(6);
        run_job("back_to_back_2", 6, 0, 0, 1, 1'b0);

        fill_random(5);
        run_job("valid_gaps", 5, 1, 0, 1, 1'b0);

        fill_random(4);
        run_job("drain_drop", 4, 0, 3, 1, 1'b1);
        fill_random(4);
        run_job("error_clear", 4, 0, 0, 1, 1'b0);

        fill_random(8);
        run_job("max_depth", 8, 0, 0, 0, 1'b1);

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/gemm_cfg_pkg.sv
hdl/gemm_types_pkg.sv
hdl/beat_sequencer.sv
hdl/operand_skew.sv
hdl/mac_pe_grid.sv
hdl/systolic_gemm_top.sv
test/systolic_gemm_properties.sv
test/tb_systolic_gemm.sv

//--- Bender.yml
package:
  name: systolic_gemm

sources:
  - files:
      - hdl/gemm_cfg_pkg.sv
      - hdl/gemm_types_pkg.sv
      - hdl/beat_sequencer.sv
      - hdl/operand_skew.sv
      - hdl/mac_pe_grid.sv
      - hdl/systolic_gemm_top.sv
  - target: test
    files:
      - test/systolic_gemm_properties.sv
      - test/tb_systolic_gemm.sv
